// File: Makefile
SIM       ?= verilator
TOP       ?= tb_conv_accel
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: build.f
src/conv_pkg.sv
src/row_buffer.sv
src/mac_engine.sv
src/conv_ctrl.sv
src/conv_accel_top.sv
sim/tb_conv_accel.sv

// File: sim/tb_conv_accel.sv
`timescale 1ns/10ps

module tb_conv_accel
    import conv_pkg::*;
();

    localparam int NUM_ROWS = 2 ** ROW_ADDR_W;
    localparam int DONE_TIMEOUT = 100;

    typedef logic [ROW_ADDR_W:0] rows_t;

    logic                clk_i;
    logic                rd_weight_rst;
    logic [WORD_W-1:0]   mem_data_i;
    logic                feature_valid_i;
    logic                weight_valid_i;
    logic                load_restart_i;
    logic                start_i;
    rows_t               num_rows_i;
    acc_t                result_o;
    logic                done_o;
    logic                busy_o;

    logic [ROW_W-1:0]    feat_rows [NUM_ROWS];
    logic [ROW_W-1:0]    wgt_rows [NUM_ROWS];
    logic [31:0]         lcg_state = 32'd11;
    acc_t                exp_result;
    int                  exp_cycles;
    int                  accept_cycle;
    int                  cycle_cnt = 0;
    int                  done_count = 0;

    conv_accel_top #(
        .LANES      (LANES),
        .ELEM_W     (ELEM_W),
        .WORD_W     (WORD_W),
        .ROW_ADDR_W (ROW_ADDR_W),
        .ACC_W      (ACC_W)
    ) u_conv_accel_top (
        .clk_i           (clk_i),
        .rd_weight_rst   (rd_weight_rst),
        .mem_data_i      (mem_data_i),
        .feature_valid_i (feature_valid_i),
        .weight_valid_i  (weight_valid_i),
        .load_restart_i  (load_restart_i),
        .start_i         (start_i),
        .num_rows_i      (num_rows_i),
        .result_o        (result_o),
        .done_o          (done_o),
        .busy_o          (busy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    //////////////////////////////////////////////////
    // reference model and checks
    //////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [ROW_W-1:0] random_row();
        logic [31:0] hi;
        logic [31:0] lo;
        lo = lcg_next();
        hi = lcg_next();
        return {hi[31:16], lo[31:16]};
    endfunction

    // signed sum of lane products over the first rows
    function automatic acc_t ref_sum(input int rows);
        acc_t  sum;
        elem_t f;
        elem_t w;
        sum = '0;
        for (int r = 0; r < rows; r++) begin
            for (int l = 0; l < LANES; l++) begin
                f = elem_t'(feat_rows[r][l*ELEM_W +: ELEM_W]);
                w = elem_t'(wgt_rows[r][l*ELEM_W +: ELEM_W]);
                sum = sum + acc_t'(int'(f) * int'(w));
            end
        end
        return sum;
    endfunction

    task automatic stop_on_failure();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        stop_on_failure();
    endtask

    task automatic check_result(input acc_t got, input acc_t expected, input string what);
        if (got !== expected) begin
            $display("ERR @%0t: %s got %0d expected %0d", $time, what, got, expected);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            $display("ERR @%0t: %s got %b expected %b", $time, what, got, expected);
            stop_on_failure();
        end
    endtask

    task automatic check_cycles(input int got, input int expected, input string what);
        if (got != expected) begin
            $display("ERR @%0t: %s got %0d expected %0d", $time, what, got, expected);
            stop_on_failure();
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk_i) begin
        if (!rd_weight_rst && done_o) begin
            done_count++;
            check_result(result_o, exp_result, "result_o at done");
            check_flag(busy_o, 1'b1, "busy_o at done");
            check_cycles(cycle_cnt - accept_cycle, exp_cycles, "cycles from start to done");
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    task automatic load_row(input logic is_weight, input logic [ROW_W-1:0] row);
        for (int w = 0; w < ROW_WORDS; w++) begin
            mem_data_i = row[w*WORD_W +: WORD_W];
            feature_valid_i = !is_weight;
            weight_valid_i = is_weight;
            @(posedge clk_i);
            #2;
        end
        feature_valid_i = 1'b0;
        weight_valid_i = 1'b0;
    endtask

    // restart both buffers, then write rows from 0
    task automatic load_set(input int n);
        load_restart_i = 1'b1;
        @(posedge clk_i);
        #2;
        load_restart_i = 1'b0;
        for (int r = 0; r < n; r++) begin
            load_row(1'b0, feat_rows[r]);
            load_row(1'b1, wgt_rows[r]);
        end
        @(posedge clk_i);
        #2;
    endtask

    // a nonzero inject_at pulses a second start that many cycles into the job
    task automatic run_job(input int rows, input acc_t expected, input int inject_at);
        int base;
        int waited;
        base = done_count;
        check_flag(busy_o, 1'b0, "busy_o before start");
        exp_result = expected;
        exp_cycles = rows + 4;
        num_rows_i = rows_t'(rows);
        start_i = 1'b1;
        @(posedge clk_i);
        #2;
        start_i = 1'b0;
        accept_cycle = cycle_cnt;
        check_flag(busy_o, 1'b1, "busy_o after start");
        waited = 0;
        while (done_count == base) begin
            start_i = (inject_at != 0) && (waited == inject_at);
            if (start_i) begin
                num_rows_i = rows_t'(1);
            end
            @(posedge clk_i);
            #2;
            waited++;
            if (waited > DONE_TIMEOUT) begin
                abort_run("timeout while waiting for done_o after a start");
            end
        end
        start_i = 1'b0;
        check_flag(done_o, 1'b0, "done_o one cycle after done");
        if (inject_at != 0) begin
            for (int i = 0; i < rows + 6; i++) begin
                @(posedge clk_i);
                #2;
            end
            check_cycles(done_count - base, 1, "done pulses for one job");
            check_flag(busy_o, 1'b0, "busy_o after job");
        end
    endtask

    initial begin
        int rows;
        rd_weight_rst = 1'b1;
        mem_data_i = '0;
        feature_valid_i = 1'b0;
        weight_valid_i = 1'b0;
        load_restart_i = 1'b0;
        start_i = 1'b0;
        num_rows_i = '0;
        repeat (10) @(posedge clk_i);
        #2;
        rd_weight_rst = 1'b0;
        repeat (2) @(posedge clk_i);
        #2;

        // idle after reset
        check_flag(busy_o, 1'b0, "busy_o after reset");
        check_flag(done_o, 1'b0, "done_o after reset");
        check_result(result_o, acc_t'(0), "result_o after reset");

        // lanes 1,2,3,4 against 5,-6,7,-8
        feat_rows[0] = 32'h04030201;
        wgt_rows[0] = 32'hF807FA05;
        load_set(1);
        run_job(1, acc_t'(-18), 0);

        for (int r = 0; r < NUM_ROWS; r++) begin
            feat_rows[r] = random_row();
            wgt_rows[r] = random_row();
        end
        load_set(NUM_ROWS);
        for (int j = 0; j < 8; j++) begin
            rows = int'(lcg_next() >> 8) % NUM_ROWS + 1;
            run_job(rows, ref_sum(rows), 0);
        end

        // extreme element values over all rows
        for (int r = 0; r < NUM_ROWS; r++) begin
            feat_rows[r] = 32'h80808080;
            wgt_rows[r] = 32'h80808080;
        end
        load_set(NUM_ROWS);
        run_job(NUM_ROWS, ref_sum(NUM_ROWS), 0);
        for (int r = 0; r < NUM_ROWS; r++) begin
            wgt_rows[r] = 32'h7F7F7F7F;
        end
        load_set(NUM_ROWS);
        run_job(NUM_ROWS, ref_sum(NUM_ROWS), 0);

        // second start while busy
        run_job(6, ref_sum(6), 2);

        // stray row and a half on the feature side, then restart and reload
        load_row(1'b0, random_row());
        mem_data_i = WORD_W'(lcg_next());
        feature_valid_i = 1'b1;
        @(posedge clk_i);
        #2;
        feature_valid_i = 1'b0;
        for (int r = 0; r < 4; r++) begin
            feat_rows[r] = random_row();
            wgt_rows[r] = random_row();
        end
        load_set(4);
        run_job(4, ref_sum(4), 0);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: src/conv_accel_top.sv
`timescale 1ns/10ps

module conv_accel_top
    import conv_pkg::*;
#(
    parameter int LANES = conv_pkg::LANES,
    parameter int ELEM_W = conv_pkg::ELEM_W,
    parameter int WORD_W = conv_pkg::WORD_W,
    parameter int ROW_ADDR_W = conv_pkg::ROW_ADDR_W,
    parameter int ACC_W = conv_pkg::ACC_W
) (
    input  logic                clk_i,
    input  logic                rd_weight_rst,
    input  logic [WORD_W-1:0]   mem_data_i,
    input  logic                feature_valid_i,
    input  logic                weight_valid_i,
    input  logic                load_restart_i,
    input  logic                start_i,
    input  logic [ROW_ADDR_W:0] num_rows_i,
    output acc_t                result_o,
    output logic                done_o,
    output logic                busy_o
);

    localparam int ROW_W = LANES * ELEM_W;

    logic                  rd_en;
    logic [ROW_ADDR_W-1:0] rd_addr;
    logic [ROW_W-1:0]      feature_row;
    logic [ROW_W-1:0]      weight_row;
    logic                  weight_ld;
    logic                  acc_clr;
    logic                  acc_en;

    //////////////////////////////////////////////////
    // feature and weight row memories
    //////////////////////////////////////////////////

    row_buffer #(
        .WORD_W     (WORD_W),
        .ROW_W      (ROW_W),
        .ROW_ADDR_W (ROW_ADDR_W)
    ) u_feature_buf (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .wr_valid_i    (feature_valid_i),
        .wr_word_i     (mem_data_i),
        .restart_i     (load_restart_i),
        .rd_en_i       (rd_en),
        .rd_addr_i     (rd_addr),
        .rd_row_o      (feature_row)
    );

    row_buffer #(
        .WORD_W     (WORD_W),
        .ROW_W      (ROW_W),
        .ROW_ADDR_W (ROW_ADDR_W)
    ) u_weight_buf (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .wr_valid_i    (weight_valid_i),
        .wr_word_i     (mem_data_i),
        .restart_i     (load_restart_i),
        .rd_en_i       (rd_en),
        .rd_addr_i     (rd_addr),
        .rd_row_o      (weight_row)
    );

    //////////////////////////////////////////////////
    // compute
    //////////////////////////////////////////////////

    mac_engine #(
        .LANES  (LANES),
        .ELEM_W (ELEM_W),
        .ACC_W  (ACC_W)
    ) u_mac (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .feature_row_i (feature_row),
        .weight_row_i  (weight_row),
        .weight_ld_i   (weight_ld),
        .acc_clr_i     (acc_clr),
        .acc_en_i      (acc_en),
        .acc_o         (result_o)
    );

    conv_ctrl #(
        .ROW_ADDR_W (ROW_ADDR_W)
    ) u_ctrl (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .start_i       (start_i),
        .num_rows_i    (num_rows_i),
        .rd_en_o       (rd_en),
        .rd_addr_o     (rd_addr),
        .weight_ld_o   (weight_ld),
        .acc_clr_o     (acc_clr),
        .acc_en_o      (acc_en),
        .busy_o        (busy_o),
        .done_o        (done_o)
    );

endmodule

// File: src/conv_ctrl.sv
`timescale 1ns/10ps

module conv_ctrl
    import conv_pkg::*;
#(
    parameter int ROW_ADDR_W = conv_pkg::ROW_ADDR_W
) (
    input  logic                  clk_i,
    input  logic                  rd_weight_rst,
    input  logic                  start_i,
    input  logic [ROW_ADDR_W:0]   num_rows_i,
    output logic                  rd_en_o,
    output logic [ROW_ADDR_W-1:0] rd_addr_o,
    output logic                  weight_ld_o,
    output logic                  acc_clr_o,
    output logic                  acc_en_o,
    output logic                  busy_o,
    output logic                  done_o
);

    ctrl_state_e           state_q;
    logic [ROW_ADDR_W-1:0] rd_cnt_q;
    logic [ROW_ADDR_W:0]   num_rows_q;
    // tap 0 loads the weight register, tap 1 accumulates, tap 2 marks the tail
    logic [2:0]            pipe_q;
    logic                  clr_q;
    logic                  accept;
    logic                  last_rd;
    logic                  rd_en;

    assign accept = (state_q == IDLE) && start_i;
    assign last_rd = ({1'b0, rd_cnt_q} == (num_rows_q - 1'b1));
    assign rd_en = (state_q == READ);

    //////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            state_q <= IDLE;
            rd_cnt_q <= '0;
            num_rows_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    // start is only taken here, so a start while busy is dropped
                    if (start_i) begin
                        state_q <= READ;
                        rd_cnt_q <= '0;
                        num_rows_q <= num_rows_i;
                    end
                end
                READ: begin
                    // one row pair per cycle
                    rd_cnt_q <= rd_cnt_q + 1'b1;
                    if (last_rd) begin
                        state_q <= DRAIN;
                    end
                end
                DRAIN: begin
                    // last row has left the delay line
                    if (pipe_q == '0) begin
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // pipeline alignment
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            pipe_q <= '0;
            clr_q <= 1'b0;
        end else begin
            pipe_q <= {pipe_q[1:0], rd_en};
            clr_q <= accept;
        end
    end

    assign rd_en_o = rd_en;
    assign rd_addr_o = rd_cnt_q;
    assign weight_ld_o = pipe_q[0];
    assign acc_en_o = pipe_q[1];
    assign acc_clr_o = clr_q;
    assign busy_o = (state_q != IDLE);
    assign done_o = (state_q == DONE);

endmodule

// File: src/conv_pkg.sv
package conv_pkg;

    //////////////////////////////////////////////////
    // datapath sizes
    //////////////////////////////////////////////////

    // elements per row
    parameter int LANES = 4;
    parameter int ELEM_W = 8;

    // external memory bus
    parameter int WORD_W = 16;

    parameter int ROW_W = LANES * ELEM_W;
    parameter int ROW_WORDS = ROW_W / WORD_W;

    // 16 rows per memory
    parameter int ROW_ADDR_W = 4;

    // 16 rows x 4 products of 8x8 bits, with headroom
    parameter int ACC_W = 24;

    //////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////

    typedef logic signed [ELEM_W-1:0] elem_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    // controller states
    typedef enum logic [1:0] {
        IDLE,
        READ,
        DRAIN,
        DONE
    } ctrl_state_e;

endpackage

// File: src/mac_engine.sv
`timescale 1ns/10ps

module mac_engine
    import conv_pkg::*;
#(
    parameter int LANES = conv_pkg::LANES,
    parameter int ELEM_W = conv_pkg::ELEM_W,
    parameter int ACC_W = conv_pkg::ACC_W
) (
    input  logic                      clk_i,
    input  logic                      rd_weight_rst,
    input  logic [LANES*ELEM_W-1:0]   feature_row_i,
    input  logic [LANES*ELEM_W-1:0]   weight_row_i,
    input  logic                      weight_ld_i,
    input  logic                      acc_clr_i,
    input  logic                      acc_en_i,
    output acc_t                      acc_o
);

    localparam int ROW_W = LANES * ELEM_W;
    localparam int PROD_W = 2 * ELEM_W;
    // products grow by one bit per tree level
    localparam int DOT_W = PROD_W + $clog2(LANES);

    logic [ROW_W-1:0]         weight_q;
    logic [ROW_W-1:0]         feature_q;
    elem_t                    feat_lane [LANES];
    elem_t                    wgt_lane [LANES];
    logic signed [DOT_W-1:0]  node [1:2*LANES-1];
    logic signed [DOT_W-1:0]  dot;
    logic signed [ACC_W-1:0]  dot_ext;
    logic signed [ACC_W-1:0]  acc_q;

    //////////////////////////////////////////////////
    // row registers
    //////////////////////////////////////////////////

    // feature row is latched beside the weight row to keep them aligned
    always_ff @(posedge clk_i) begin
        if (weight_ld_i) begin
            weight_q <= weight_row_i;
            feature_q <= feature_row_i;
        end
    end

    //////////////////////////////////////////////////
    // lane multipliers and adder tree
    //////////////////////////////////////////////////

    // heap layout: leaves at LANES..2*LANES-1, root at node 1
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        assign feat_lane[i] = feature_q[i*ELEM_W +: ELEM_W];
        assign wgt_lane[i] = weight_q[i*ELEM_W +: ELEM_W];
        assign node[LANES+i] = DOT_W'(feat_lane[i] * wgt_lane[i]);
    end

    for (genvar k = 1; k < LANES; k++) begin : g_tree
        assign node[k] = node[2*k] + node[2*k+1];
    end

    assign dot = node[1];
    assign dot_ext = {{(ACC_W-DOT_W){dot[DOT_W-1]}}, dot};

    //////////////////////////////////////////////////
    // row accumulator
    //////////////////////////////////////////////////

    // clear wins over accumulate
    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            acc_q <= '0;
        end else if (acc_clr_i) begin
            acc_q <= '0;
        end else if (acc_en_i) begin
            acc_q <= acc_q + dot_ext;
        end
    end

    assign acc_o = acc_q;

endmodule

// File: src/row_buffer.sv
`timescale 1ns/10ps

module row_buffer #(
    parameter int WORD_W = 16,
    parameter int ROW_W = 32,
    parameter int ROW_ADDR_W = 4
) (
    input  logic                  clk_i,
    input  logic                  rd_weight_rst,
    input  logic                  wr_valid_i,
    input  logic [WORD_W-1:0]     wr_word_i,
    input  logic                  restart_i,
    input  logic                  rd_en_i,
    input  logic [ROW_ADDR_W-1:0] rd_addr_i,
    output logic [ROW_W-1:0]      rd_row_o
);

    localparam int ROW_WORDS = ROW_W / WORD_W;
    localparam int CNT_W = (ROW_WORDS > 1) ? $clog2(ROW_WORDS) : 1;
    localparam int DEPTH = 2 ** ROW_ADDR_W;

    logic [CNT_W-1:0]      word_cnt_q;
    logic [ROW_W-1:0]      pack_q;
    logic                  wr_pend_q;
    logic [ROW_ADDR_W-1:0] wr_ptr_q;
    logic [ROW_W-1:0]      mem [DEPTH];
    logic [ROW_W-1:0]      rd_row_q;
    logic                  last_word;

    assign last_word = (word_cnt_q == CNT_W'(ROW_WORDS - 1));

    //////////////////////////////////////////////////
    // word packer
    //////////////////////////////////////////////////

    // new words enter at the top, so the first word ends up in the low bits
    always_ff @(posedge clk_i) begin
        if (wr_valid_i) begin
            pack_q <= {wr_word_i, pack_q[ROW_W-1:WORD_W]};
        end
    end

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            word_cnt_q <= '0;
            wr_pend_q <= 1'b0;
        end else if (restart_i) begin
            word_cnt_q <= '0;
            wr_pend_q <= 1'b0;
        end else begin
            // row complete, write it on the following edge
            wr_pend_q <= wr_valid_i && last_word;
            if (wr_valid_i) begin
                if (last_word) begin
                    word_cnt_q <= '0;
                end else begin
                    word_cnt_q <= word_cnt_q + 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // row memory
    //////////////////////////////////////////////////

    // pointer wraps at the memory depth
    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            wr_ptr_q <= '0;
        end else if (restart_i) begin
            wr_ptr_q <= '0;
        end else if (wr_pend_q) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_pend_q) begin
            mem[wr_ptr_q] <= pack_q;
        end
    end

    // registered read port, one cycle latency
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_row_q <= mem[rd_addr_i];
        end
    end

    assign rd_row_o = rd_row_q;

endmodule
